// File: rtl/rv_pkg.sv
package rv_pkg;

    // ##########################################################
    // widths
    // ##########################################################

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [31:0]           instr_t;
    typedef logic [REG_ADDR_W-1:0] reg_idx_t;

    // ##########################################################
    // encodings
    // ##########################################################

    // major opcodes, bits 6:0 of the instruction word
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B      // lui, operand b straight through
    } alu_op_e;

endpackage

// File: rtl/rv_regs.sv
`timescale 1ns/1ps

module rv_regs (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  rv_pkg::reg_idx_t        i_rs1,
    input  rv_pkg::reg_idx_t        i_rs2,
    input  rv_pkg::reg_idx_t        i_rd,
    input  logic                    i_write,
    input  logic [rv_pkg::XLEN-1:0] i_wdata,
    output logic [rv_pkg::XLEN-1:0] o_rdata1,
    output logic [rv_pkg::XLEN-1:0] o_rdata2
);

    import rv_pkg::*;

    logic [XLEN-1:0] regs [1:31];   // no storage for x0

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_write && (i_rd != '0)) begin
            regs[i_rd] <= i_wdata;
        end
    end

    assign o_rdata1 = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rdata2 = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

// File: rtl/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch #(
    parameter logic [31:0] RESET_ADDR       = 32'h0000_0000,
    parameter int          IADDR_SPACE_BITS = 16
) (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_buf_full,
    // instruction bus
    output logic                        o_instr_req,
    output logic [IADDR_SPACE_BITS-1:2] o_instr_addr,
    input  logic                        i_instr_ack,
    input  rv_pkg::instr_t              i_instr_data,
    // buffer write side
    output logic                        o_push,
    output rv_pkg::instr_t              o_push_instr,
    output logic [IADDR_SPACE_BITS-1:2] o_push_pc
);

    logic [IADDR_SPACE_BITS-1:2] pc;
    logic                        ack;

    assign ack = o_instr_req & i_instr_ack;   // stray acks are ignored

    // ##########################################################
    // request state and pc
    // ##########################################################

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_instr_req <= 1'b0;
            pc          <= RESET_ADDR[IADDR_SPACE_BITS-1:2];
        end else if (ack) begin
            o_instr_req <= 1'b0;              // at least one idle cycle
            pc          <= pc + 1'b1;
        end else if (!o_instr_req && !i_buf_full) begin
            o_instr_req <= 1'b1;
        end
    end

    assign o_instr_addr = pc;

    // word goes into the buffer in the ack cycle
    assign o_push       = ack;
    assign o_push_instr = i_instr_data;
    assign o_push_pc    = pc;

endmodule

// File: rtl/rv_instr_buf.sv
`timescale 1ns/1ps

module rv_instr_buf #(
    parameter int IADDR_SPACE_BITS    = 16,
    parameter int INSTR_BUF_ADDR_SIZE = 2     // depth is 2**N words
) (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_push,
    input  rv_pkg::instr_t              i_push_instr,
    input  logic [IADDR_SPACE_BITS-1:2] i_push_pc,
    input  logic                        i_pop,
    output logic                        o_full,
    output logic                        o_empty,
    output rv_pkg::instr_t              o_head_instr,
    output logic [IADDR_SPACE_BITS-1:2] o_head_pc
);

    import rv_pkg::*;

    instr_t                      mem_instr [0:2**INSTR_BUF_ADDR_SIZE-1];
    logic [IADDR_SPACE_BITS-1:2] mem_pc    [0:2**INSTR_BUF_ADDR_SIZE-1];

    logic [INSTR_BUF_ADDR_SIZE-1:0] wr_ptr;
    logic [INSTR_BUF_ADDR_SIZE-1:0] rd_ptr;
    logic [INSTR_BUF_ADDR_SIZE:0]   count;
    logic                           do_push;
    logic                           do_pop;

    assign o_full  = count[INSTR_BUF_ADDR_SIZE];  // msb only set at full depth
    assign o_empty = (count == '0);

    assign do_push = i_push & ~o_full;
    assign do_pop  = i_pop & ~o_empty;

    always_ff @(posedge i_clk) begin
        if (do_push) begin
            mem_instr[wr_ptr] <= i_push_instr;
            mem_pc[wr_ptr]    <= i_push_pc;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // both or neither
            endcase
        end
    end

    assign o_head_instr = mem_instr[rd_ptr];
    assign o_head_pc    = mem_pc[rd_ptr];

endmodule

// File: rtl/rv_exec.sv
`timescale 1ns/1ps

module rv_exec #(
    parameter int IADDR_SPACE_BITS = 16
) (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_hold,
    input  logic                        i_empty,
    input  rv_pkg::instr_t              i_head_instr,
    input  logic [IADDR_SPACE_BITS-1:2] i_head_pc,
    output logic                        o_pop,
    output logic                        o_retire_valid,
    output logic [IADDR_SPACE_BITS-1:2] o_retire_pc,
    output rv_pkg::reg_idx_t            o_retire_rd,
    output logic [rv_pkg::XLEN-1:0]     o_retire_data,
    output logic                        o_retire_illegal
);

    import rv_pkg::*;

    opcode_e          opcode;
    alu_op_e          alu_op;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    reg_idx_t         rs1;
    reg_idx_t         rs2;
    reg_idx_t         rd;
    logic [XLEN-1:0]  imm;
    logic             use_imm;
    logic             legal;
    logic [XLEN-1:0]  rdata1;
    logic [XLEN-1:0]  rdata2;
    logic [XLEN-1:0]  op_b;
    logic [XLEN-1:0]  result;
    logic             wr_en;

    // funct3 to alu op, alt selects sub/sra
    function automatic alu_op_e f3_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // ##########################################################
    // decode
    // ##########################################################

    assign opcode = opcode_e'(i_head_instr[6:0]);
    assign funct3 = i_head_instr[14:12];
    assign funct7 = i_head_instr[31:25];
    assign rs1    = i_head_instr[19:15];
    assign rs2    = i_head_instr[24:20];
    assign rd     = i_head_instr[11:7];

    always_comb begin
        alu_op  = ALU_ADD;
        use_imm = 1'b1;
        imm     = {{20{i_head_instr[31]}}, i_head_instr[31:20]};   // I-type
        legal   = 1'b0;
        case (opcode)
            OPC_LUI: begin
                alu_op = ALU_PASS_B;
                imm    = {i_head_instr[31:12], 12'b0};
                legal  = 1'b1;
            end
            OPC_OP_IMM: begin
                alu_op = f3_op(funct3, (funct3 == 3'b101) & funct7[5]);
                if (funct3 == 3'b001)
                    legal = (funct7 == 7'b0000000);
                else if (funct3 == 3'b101)
                    legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                else
                    legal = 1'b1;
            end
            OPC_OP: begin
                use_imm = 1'b0;
                alu_op  = f3_op(funct3, funct7[5]);
                legal   = (funct7 == 7'b0000000) ||
                          ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
            end
            default: legal = 1'b0;
        endcase
    end

    // ##########################################################
    // alu
    // ##########################################################

    assign op_b = use_imm ? imm : rdata2;

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = rdata1 + op_b;
            ALU_SUB:  result = rdata1 - op_b;
            ALU_SLL:  result = rdata1 << op_b[4:0];
            ALU_SLT:  result = {31'b0, $signed(rdata1) < $signed(op_b)};
            ALU_SLTU: result = {31'b0, rdata1 < op_b};
            ALU_XOR:  result = rdata1 ^ op_b;
            ALU_SRL:  result = rdata1 >> op_b[4:0];
            ALU_SRA:  result = $unsigned($signed(rdata1) >>> op_b[4:0]);
            ALU_OR:   result = rdata1 | op_b;
            ALU_AND:  result = rdata1 & op_b;
            default:  result = op_b;          // pass b
        endcase
    end

    assign o_pop = ~i_empty & ~i_hold;
    assign wr_en = o_pop & legal & (rd != '0);

    rv_regs u_regs (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_rs1    (rs1),
        .i_rs2    (rs2),
        .i_rd     (rd),
        .i_write  (wr_en),
        .i_wdata  (result),
        .o_rdata1 (rdata1),
        .o_rdata2 (rdata2)
    );

    // retire, same edge as the register write
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_retire_valid <= 1'b0;
        end else begin
            o_retire_valid <= o_pop;
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_pop) begin
            o_retire_pc      <= i_head_pc;
            o_retire_illegal <= ~legal;
            o_retire_rd      <= wr_en ? rd : '0;
            o_retire_data    <= wr_en ? result : '0;
        end
    end

endmodule

// File: rtl/rv_core.sv
`timescale 1ns/1ps

module rv_core #(
    parameter logic [31:0] RESET_ADDR          = 32'h0000_0000,
    parameter int          IADDR_SPACE_BITS    = 16,
    parameter int          INSTR_BUF_ADDR_SIZE = 2
) (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_hold,
    // instruction bus
    output logic                        o_instr_req,
    output logic [IADDR_SPACE_BITS-1:2] o_instr_addr,
    input  logic                        i_instr_ack,
    input  rv_pkg::instr_t              i_instr_data,
    // retire port
    output logic                        o_retire_valid,
    output logic [IADDR_SPACE_BITS-1:2] o_retire_pc,
    output rv_pkg::reg_idx_t            o_retire_rd,
    output logic [rv_pkg::XLEN-1:0]     o_retire_data,
    output logic                        o_retire_illegal
);

    import rv_pkg::*;

    logic                        push;
    instr_t                      push_instr;
    logic [IADDR_SPACE_BITS-1:2] push_pc;
    logic                        buf_full;
    logic                        buf_empty;
    logic                        pop;
    instr_t                      head_instr;
    logic [IADDR_SPACE_BITS-1:2] head_pc;

    rv_fetch #(
        .RESET_ADDR       (RESET_ADDR),
        .IADDR_SPACE_BITS (IADDR_SPACE_BITS)
    ) u_fetch (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_buf_full   (buf_full),
        .o_instr_req  (o_instr_req),
        .o_instr_addr (o_instr_addr),
        .i_instr_ack  (i_instr_ack),
        .i_instr_data (i_instr_data),
        .o_push       (push),
        .o_push_instr (push_instr),
        .o_push_pc    (push_pc)
    );

    rv_instr_buf #(
        .IADDR_SPACE_BITS    (IADDR_SPACE_BITS),
        .INSTR_BUF_ADDR_SIZE (INSTR_BUF_ADDR_SIZE)
    ) u_buf (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_push       (push),
        .i_push_instr (push_instr),
        .i_push_pc    (push_pc),
        .i_pop        (pop),
        .o_full       (buf_full),
        .o_empty      (buf_empty),
        .o_head_instr (head_instr),
        .o_head_pc    (head_pc)
    );

    rv_exec #(
        .IADDR_SPACE_BITS (IADDR_SPACE_BITS)
    ) u_exec (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .i_hold           (i_hold),
        .i_empty          (buf_empty),
        .i_head_instr     (head_instr),
        .i_head_pc        (head_pc),
        .o_pop            (pop),
        .o_retire_valid   (o_retire_valid),
        .o_retire_pc      (o_retire_pc),
        .o_retire_rd      (o_retire_rd),
        .o_retire_data    (o_retire_data),
        .o_retire_illegal (o_retire_illegal)
    );

endmodule

// File: dv/tb_rv_model.svh
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

// ##########################################################
// reference model
// ##########################################################

localparam int KIND_OP_IMM  = 0;
localparam int KIND_MIX     = 1;
localparam int KIND_ILLEGAL = 2;

logic [31:0] model_regs [0:31];
logic [4:0]  last_rd;     // last destination, reused as a source

function automatic void model_reset();
    for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
    end
endfunction

function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    logic signed [31:0] sa;
    sa = a;
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3:    return (a < b) ? 32'd1 : 32'd0;
        3'd4:    return a ^ b;
        3'd5: begin
            if (alt)
                return sa >>> b[4:0];
            return a >> b[4:0];
        end
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

// executes one word and updates the model registers
function automatic void model_step(input logic [31:0] w, output logic ill,
                                   output logic [4:0] rd_o, output logic [31:0] data_o);
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [4:0]  rd;
    logic [31:0] res;
    logic        ok;
    f3  = w[14:12];
    f7  = w[31:25];
    rd  = w[11:7];
    ok  = 1'b0;
    res = '0;
    if (w[6:0] == 7'h37) begin
        ok  = 1'b1;
        res = {w[31:12], 12'h000};
    end else if (w[6:0] == 7'h13) begin
        if (f3 == 3'd1)
            ok = (f7 == 7'h00);
        else if (f3 == 3'd5)
            ok = (f7 == 7'h00) || (f7 == 7'h20);
        else
            ok = 1'b1;
        // shift amount sits in the low immediate bits
        res = model_alu(f3, (f3 == 3'd5) && f7[5], model_regs[w[19:15]],
                        {{20{w[31]}}, w[31:20]});
    end else if (w[6:0] == 7'h33) begin
        ok  = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
        res = model_alu(f3, f7[5], model_regs[w[19:15]], model_regs[w[24:20]]);
    end
    if (ok && (rd != 5'd0))
        model_regs[rd] = res;
    ill    = !ok;
    rd_o   = (ok && (rd != 5'd0)) ? rd : 5'd0;
    data_o = (ok && (rd != 5'd0)) ? res : 32'd0;
endfunction

// ##########################################################
// random instruction generator
// ##########################################################

function automatic logic [4:0] pick_src();
    if ($urandom_range(0, 1) == 0)
        return last_rd;
    return 5'($urandom_range(0, 15));
endfunction

function automatic logic [31:0] gen_op_imm();
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [11:0] imm;
    logic [31:0] w;
    f3  = 3'($urandom_range(0, 7));
    rd  = 5'($urandom_range(0, 15));
    imm = 12'($urandom);
    if (f3 == 3'd1)
        imm[11:5] = 7'h00;
    else if (f3 == 3'd5)
        imm[11:5] = ($urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;   // srai or srli
    w       = {imm, pick_src(), f3, rd, 7'h13};
    last_rd = rd;
    return w;
endfunction

function automatic logic [31:0] gen_op();
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [6:0]  f7;
    logic [31:0] w;
    f3 = 3'($urandom_range(0, 7));
    rd = 5'($urandom_range(0, 15));
    f7 = 7'h00;
    if (((f3 == 3'd0) || (f3 == 3'd5)) && ($urandom_range(0, 1) == 1))
        f7 = 7'h20;
    w       = {f7, pick_src(), pick_src(), f3, rd, 7'h33};
    last_rd = rd;
    return w;
endfunction

function automatic logic [31:0] gen_lui();
    logic [4:0] rd;
    rd      = 5'($urandom_range(0, 15));
    last_rd = rd;
    return {20'($urandom), rd, 7'h37};
endfunction

function automatic logic [31:0] gen_illegal();
    logic [31:0] w;
    w = $urandom;
    case ($urandom_range(0, 4))
        0: w[6:0] = 7'h03;    // load
        1: w[6:0] = 7'h63;    // branch
        2: w[6:0] = 7'h17;    // auipc
        3: begin              // mul group
            w[31:25] = 7'h01;
            w[6:0]   = 7'h33;
        end
        default: begin        // slli with bad funct7
            w[31:25] = 7'h20;
            w[14:12] = 3'd1;
            w[6:0]   = 7'h13;
        end
    endcase
    return w;
endfunction

function automatic logic [31:0] gen_instr(input int kind);
    int pick;
    pick = $urandom_range(0, 9);
    if (kind == KIND_OP_IMM)
        return gen_op_imm();
    if ((kind == KIND_ILLEGAL) && (pick < 2))
        return gen_illegal();
    pick = $urandom_range(0, 9);
    if (pick < 2)
        return gen_lui();
    if (pick < 5)
        return gen_op_imm();
    return gen_op();
endfunction

`endif

// File: dv/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    localparam int PROG_WORDS   = 256;
    localparam int N_INSTR      = 200;
    localparam int RETIRE_LIMIT = 200;

    logic        i_clk;
    logic        i_rst;
    logic        i_hold;
    logic        i_instr_ack;
    logic [31:0] i_instr_data;
    logic        o_instr_req;
    logic [13:0] o_instr_addr;
    logic        o_retire_valid;
    logic [13:0] o_retire_pc;
    logic [4:0]  o_retire_rd;
    logic [31:0] o_retire_data;
    logic        o_retire_illegal;

    logic [31:0] prog [0:PROG_WORDS-1];
    int          errors;
    int          tests_ok;
    int          tests_bad;
    bit          timed_out;
    bit          hold_en;
    int          hold_left;
    int          ack_wait;

    `include "tb_rv_model.svh"

    rv_core #(
        .RESET_ADDR          (32'h0000_0000),
        .IADDR_SPACE_BITS    (16),
        .INSTR_BUF_ADDR_SIZE (2)
    ) u_rv_core (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .i_hold           (i_hold),
        .o_instr_req      (o_instr_req),
        .o_instr_addr     (o_instr_addr),
        .i_instr_ack      (i_instr_ack),
        .i_instr_data     (i_instr_data),
        .o_retire_valid   (o_retire_valid),
        .o_retire_pc      (o_retire_pc),
        .o_retire_rd      (o_retire_rd),
        .o_retire_data    (o_retire_data),
        .o_retire_illegal (o_retire_illegal)
    );

    always #50 i_clk = ~i_clk;

    // past the program, lui x0 carrying the word address
    function automatic logic [31:0] filler(input logic [13:0] addr);
        return {6'b0, addr, 5'd0, 7'h37};
    endfunction

    function automatic logic [31:0] mem_word(input logic [13:0] addr);
        if (addr < PROG_WORDS)
            return prog[addr];
        return filler(addr);
    endfunction

    task automatic fill_program(input int kind, input int n);
        last_rd = 5'd0;
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = (i < n) ? gen_instr(kind) : filler(14'(i));
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("FAIL %0t: %s expected %h got %h", $time, what, exp, act);
            errors++;
        end
    endtask

    // ##########################################################
    // per-cycle drivers
    // ##########################################################

    task automatic drive_memory();
        if (i_rst || i_instr_ack || !o_instr_req) begin
            i_instr_ack = 1'b0;
            ack_wait    = -1;
        end else begin
            if (ack_wait < 0)
                ack_wait = $urandom_range(0, 3);
            if (ack_wait == 0) begin
                i_instr_ack  = 1'b1;
                i_instr_data = mem_word(o_instr_addr);
            end
            ack_wait--;
        end
    endtask

    task automatic drive_hold();
        if (hold_left > 0)
            hold_left--;
        else if (hold_en && ($urandom_range(0, 9) == 0))
            hold_left = $urandom_range(1, 8);
        i_hold = (hold_left > 0);
    endtask

    task automatic tick();
        @(posedge i_clk);
        #1;
        // i_hold still has the level of the cycle that just ended
        check_value("retire while hold high", 32'd0, {31'd0, o_retire_valid & i_hold});
        drive_memory();
        drive_hold();
    endtask

    task automatic apply_reset();
        i_rst     = 1'b1;
        hold_en   = 1'b0;
        hold_left = 0;
        i_hold    = 1'b0;
        repeat (4) begin
            tick();
            check_value("o_retire_valid in reset", 32'd0, {31'd0, o_retire_valid});
            check_value("o_instr_req in reset", 32'd0, {31'd0, o_instr_req});
        end
        i_rst = 1'b0;
        model_reset();
    endtask

    task automatic report_test(input string name);
        if ((errors == 0) && !timed_out) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d mismatches, timeout %0d", name, errors, timed_out);
        end
    endtask

    // ##########################################################
    // tests
    // ##########################################################

    task automatic run_reset_test();
        int waited;
        errors = 0;
        fill_program(KIND_MIX, 0);
        apply_reset();
        waited = 0;
        while (!o_instr_req && (waited < RETIRE_LIMIT)) begin
            tick();
            check_value("o_retire_valid after reset", 32'd0, {31'd0, o_retire_valid});
            waited++;
        end
        if (!o_instr_req) begin
            $display("%0t: no instruction request came after reset", $time);
            timed_out = 1'b1;
        end else begin
            check_value("cycles to first request", 32'd1, waited);
            check_value("first request address", 32'd0, {16'd0, o_instr_addr, 2'b00});
        end
        report_test("reset");
    endtask

    task automatic run_program(input string name, input int kind, input bit with_hold);
        logic        exp_ill;
        logic [4:0]  exp_rd;
        logic [31:0] exp_data;
        int          waited;
        int          idx;
        errors = 0;
        fill_program(kind, N_INSTR);
        apply_reset();
        hold_en = with_hold;
        for (idx = 0; (idx < N_INSTR) && !timed_out; idx++) begin
            waited = 0;
            do begin
                tick();
                waited++;
            end while (!o_retire_valid && (waited < RETIRE_LIMIT));
            if (!o_retire_valid) begin
                $display("%0t: no instruction retired within %0d cycles", $time, RETIRE_LIMIT);
                timed_out = 1'b1;
            end else begin
                model_step(prog[idx], exp_ill, exp_rd, exp_data);
                check_value("retire pc", idx * 4, {16'd0, o_retire_pc, 2'b00});
                check_value("retire illegal", {31'd0, exp_ill}, {31'd0, o_retire_illegal});
                check_value("retire rd", {27'd0, exp_rd}, {27'd0, o_retire_rd});
                check_value("retire data", exp_data, o_retire_data);
            end
        end
        hold_en = 1'b0;
        report_test(name);
    endtask

    initial begin
        i_clk        = 1'b0;
        i_rst        = 1'b1;
        i_hold       = 1'b0;
        i_instr_ack  = 1'b0;
        i_instr_data = '0;
        hold_en      = 1'b0;
        hold_left    = 0;
        ack_wait     = -1;
        timed_out    = 1'b0;
        tests_ok     = 0;
        tests_bad    = 0;
        void'($urandom(32'hc4df_d5a9));

        run_reset_test();
        if (!timed_out)
            run_program("op_imm", KIND_OP_IMM, 1'b0);
        if (!timed_out)
            run_program("op_and_lui", KIND_MIX, 1'b0);
        if (!timed_out)
            run_program("back_pressure", KIND_MIX, 1'b1);
        if (!timed_out)
            run_program("illegal", KIND_ILLEGAL, 1'b1);

        $display("tests ok: %0d, tests with mismatches: %0d", tests_ok, tests_bad);
        if ((tests_bad == 0) && !timed_out)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: build.f
+incdir+dv
rtl/rv_pkg.sv
rtl/rv_regs.sv
rtl/rv_fetch.sv
rtl/rv_instr_buf.sv
rtl/rv_exec.sv
rtl/rv_core.sv
dv/tb_rv_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
FLAGS     ?= --binary --timing -Wno-fatal

PASS_MSG := Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR FLAGS"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
